// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_sld_unit -f vlog.f -o tb_sld_unit
./obj_dir/tb_sld_unit

// File: sld_assertions.sv
// Handshake and reset-state checks bound to the slide unit
module sld_assertions (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 req_valid_i,
  input logic                 req_ready_o,
  input logic                 rsp_valid_o,
  input logic                 vrf_re_o,
  input logic                 vrf_we_o,
  input sld_pkg::vreg_addr_t  vrf_waddr_o,
  input sld_pkg::vreg_data_t  vrf_wdata_o,
  input sld_pkg::vreg_be_t    vrf_wbe_o,
  input logic                 vrf_wvalid_i
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////
  // Reset state
  //////////////////////////////

  reset_state_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !vrf_we_o && !vrf_re_o && !rsp_valid_o && req_ready_o)
    else $error("outputs are not in their reset state right after reset");

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  // Write request holds until the VRF acknowledges it
  write_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    vrf_we_o && !vrf_wvalid_i |=> vrf_we_o && $stable(vrf_waddr_o)
                                  && $stable(vrf_wdata_o) && $stable(vrf_wbe_o))
    else $error("write request changed before its acknowledge");

  busy_after_accept_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && req_ready_o |=> !req_ready_o)
    else $error("request ready stayed high after a request was accepted");

  // Ready only comes back together with the response
  ready_with_rsp_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_ready_o) |-> rsp_valid_o)
    else $error("request ready rose without a response");

  rsp_single_cycle_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o)
    else $error("response valid lasted more than one cycle");

endmodule

// File: sld_byte_counter.sv
// Slide byte counter with first/last word detection, per-word byte count and VRF addresses
`include "sld_config.svh"

module sld_byte_counter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  start_i,
  input  logic                  advance_i,
  input  logic                  prefetch_i,
  input  sld_pkg::vlen_t        vl_i,
  input  sld_pkg::vlen_t        amount_i,
  input  sld_pkg::sld_op_e      op_i,
  input  sld_pkg::vreg_idx_t    vs2_i,
  input  sld_pkg::vreg_idx_t    vd_i,

  output logic                  first_o,
  output logic                  last_o,
  output logic                  last_done_o,
  output logic                  first_straddle_o,
  output sld_pkg::vlen_t        delta_o,
  output sld_pkg::vlen_t        count_o,
  output sld_pkg::vreg_addr_t   raddr_o,
  output sld_pkg::vreg_addr_t   waddr_o
);

  localparam int unsigned off_w      = $clog2(`SLD_WORD_BYTES);
  localparam int unsigned word_idx_w = $clog2(`SLD_WORDS_PER_VREG);
  localparam int unsigned vlen_w     = $bits(sld_pkg::vlen_t);

  sld_pkg::vlen_t          count_q, rem, room;
  logic                    first_q, pf_done_q, run_step;
  logic [vlen_w-off_w-1:0] cur_word, amt_word;
  logic [off_w-1:0]        amt_off;
  sld_pkg::vreg_addr_t     src_base, dst_base, src_word;

  // Prefetch reads load the overflow register only
  assign run_step = advance_i && !prefetch_i;

  assign cur_word = count_q[vlen_w-1:off_w];
  assign amt_word = amount_i[vlen_w-1:off_w];
  assign amt_off  = amount_i[off_w-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      first_q   <= 1'b0;
      pf_done_q <= 1'b0;
    end else if (start_i) begin
      // Slide-up skips the destination bytes below the amount
      count_q   <= (op_i == sld_pkg::SLD_UP) ? amount_i : '0;
      first_q   <= 1'b1;
      pf_done_q <= 1'b0;
    end else begin
      if (run_step) begin
        count_q <= count_q + delta_o;
        first_q <= 1'b0;
      end
      if (prefetch_i && advance_i) begin
        pf_done_q <= 1'b1;
      end
    end
  end

  // Bytes left in the vector versus bytes left in this word
  assign rem     = vl_i - count_q;
  assign room    = sld_pkg::vlen_t'(`SLD_WORD_BYTES) - sld_pkg::vlen_t'(count_q[off_w-1:0]);
  assign last_o  = (rem <= room);
  assign delta_o = last_o ? rem : room;

  assign first_o          = first_q;
  assign count_o          = count_q;
  assign last_done_o      = last_o && run_step;
  assign first_straddle_o = (amt_off != '0) && !pf_done_q && !(prefetch_i && advance_i);

  //////////////////////////////
  // Address generation
  //////////////////////////////

  assign src_base = {vs2_i, {word_idx_w{1'b0}}};
  assign dst_base = {vd_i, {word_idx_w{1'b0}}};

  always_comb begin
    if (prefetch_i) begin
      src_word = sld_pkg::vreg_addr_t'(amt_word);
    end else if (op_i == sld_pkg::SLD_UP) begin
      src_word = sld_pkg::vreg_addr_t'(cur_word) - sld_pkg::vreg_addr_t'(amt_word);
    end else begin
      // With a split offset the word after the prefetched one comes next
      src_word = sld_pkg::vreg_addr_t'(cur_word) + sld_pkg::vreg_addr_t'(amt_word)
               + sld_pkg::vreg_addr_t'(amt_off != '0);
    end
  end

  assign raddr_o = src_base + src_word;
  assign waddr_o = dst_base + sld_pkg::vreg_addr_t'(cur_word);

endmodule

// File: sld_config.svh
// Slide unit configuration with VRF word size, vector geometry and register count
`ifndef SLD_CONFIG_SVH
`define SLD_CONFIG_SVH

//////////////////////////////
// VRF geometry
//////////////////////////////

// Bytes per VRF word
`define SLD_WORD_BYTES 4

// Words per vector register, so the maximum vector length is 16 bytes
`define SLD_WORDS_PER_VREG 4

// Architectural vector registers
`define SLD_NR_VREGS 32

//////////////////////////////
// Instruction tracking
//////////////////////////////

// Width of the instruction id carried to the response
`define SLD_ID_WIDTH 3

`endif

// File: sld_ctrl_fsm.sv
// Slide control FSM sequencing prefetch, run and the wait for the last write acknowledge
module sld_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_n_i,

  // Operation register status
  input  logic              req_valid_i,
  input  sld_pkg::sld_op_e  op_i,
  input  sld_pkg::sld_id_t  req_id_i,

  // Counter status
  input  logic              first_straddle_i,
  input  logic              last_done_i,

  // VRF write acknowledge
  input  logic              vrf_wvalid_i,

  output logic              prefetch_o,
  output logic              run_o,
  output logic              req_done_o,
  output logic              rsp_valid_o,
  output sld_pkg::sld_id_t  rsp_id_o
);

  typedef enum logic [1:0] {
    IDLE,
    PREFETCH,
    RUN,
    WAIT_WVALID
  } state_e;

  state_e           state_q, state_d;
  sld_pkg::sld_id_t id_q;
  logic             rsp_valid_q;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;

    unique case (state_q)
      IDLE: begin
        // The register still holds the finished request during the response cycle
        if (req_valid_i && !rsp_valid_q) begin
          if (op_i == sld_pkg::SLD_DOWN && first_straddle_i) begin
            state_d = PREFETCH;
          end else begin
            state_d = RUN;
          end
        end
      end
      PREFETCH: begin
        // Straddle flag drops as soon as the prefetch read is taken
        if (!first_straddle_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (last_done_i) begin
          state_d = WAIT_WVALID;
        end
      end
      WAIT_WVALID: begin
        if (vrf_wvalid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= (state_q == WAIT_WVALID) && vrf_wvalid_i;
    end
  end

  // Id of the instruction draining its last write
  always_ff @(posedge clk_i) begin
    if (state_q == RUN && last_done_i) begin
      id_q <= req_id_i;
    end
  end

  assign prefetch_o  = (state_q == PREFETCH);
  assign run_o       = (state_q == RUN);

  // Operation register empties together with the response
  assign req_done_o  = rsp_valid_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = id_q;

endmodule

// File: sld_pkg.sv
// Slide unit package with the element width, opcode, request, write and response types
`include "sld_config.svh"

package sld_pkg;

  // Element width code, used directly as a byte shift
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  // Slide direction
  typedef enum logic {
    SLD_UP   = 1'b0,
    SLD_DOWN = 1'b1
  } sld_op_e;

  //////////////////////////////
  // VRF side
  //////////////////////////////

  typedef logic [$clog2(`SLD_NR_VREGS*`SLD_WORDS_PER_VREG)-1:0] vreg_addr_t;
  typedef logic [8*`SLD_WORD_BYTES-1:0]                        vreg_data_t;
  typedef logic [`SLD_WORD_BYTES-1:0]                          vreg_be_t;
  typedef logic [$clog2(`SLD_NR_VREGS)-1:0]                    vreg_idx_t;

  // Byte count up to and including the maximum vector length
  typedef logic [$clog2(`SLD_WORD_BYTES*`SLD_WORDS_PER_VREG):0] vlen_t;

  typedef logic [`SLD_ID_WIDTH-1:0] sld_id_t;

  // Request after conversion to bytes
  typedef struct packed {
    sld_op_e   op;
    vsew_e     vsew;
    vlen_t     vl;
    vlen_t     amount;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    sld_id_t   id;
  } sld_req_t;

  // One word write towards the VRF
  typedef struct packed {
    vreg_addr_t waddr;
    vreg_data_t wdata;
    vreg_be_t   wbe;
  } vrf_wreq_t;

endpackage

// File: sld_shifter.sv
// Slide byte shifter with overflow register, zero fill and byte-enable generation
`include "sld_config.svh"

module sld_shifter (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  sld_pkg::sld_op_e     op_i,
  input  sld_pkg::vlen_t       amount_i,
  input  sld_pkg::vlen_t       count_i,
  input  sld_pkg::vlen_t       delta_i,
  input  logic                 first_i,
  input  logic                 load_i,
  input  logic                 clear_i,
  input  sld_pkg::vreg_data_t  rdata_i,

  output sld_pkg::vreg_data_t  wdata_o,
  output sld_pkg::vreg_be_t    wbe_o
);

  localparam int unsigned wb        = `SLD_WORD_BYTES;
  localparam int unsigned off_w     = $clog2(wb);
  localparam int unsigned max_bytes = wb * `SLD_WORDS_PER_VREG;

  logic [off_w-1:0]    off;
  logic [off_w-1:0]    lo_byte;
  sld_pkg::vreg_data_t ovf_q, spill, merged;

  // In-word part of the slide amount
  assign off = amount_i[off_w-1:0];

  //////////////////////////////
  // Byte shift and merge
  //////////////////////////////

  always_comb begin
    spill  = '0;
    merged = '0;

    if (op_i == sld_pkg::SLD_UP) begin
      // Low bytes come from the tail of the previous source word
      merged = (rdata_i << (8 * off)) | ovf_q;
      if (off != '0) begin
        spill = rdata_i >> (8 * (wb - off));
      end
    end else begin
      if (off == '0) begin
        merged = rdata_i;
      end else begin
        // Upper bytes of the held word then the head of the new one
        merged = ovf_q | (rdata_i << (8 * (wb - off)));
      end
      spill = rdata_i >> (8 * off);
    end

    // Source bytes past the maximum vector length read as zero
    for (int b = 0; b < wb; b++) begin
      if (op_i == sld_pkg::SLD_DOWN &&
          (int'(count_i) + b + int'(amount_i) >= max_bytes)) begin
        merged[8*b +: 8] = 8'h00;
      end
    end
  end

  assign wdata_o = merged;

  //////////////////////////////
  // Byte enables
  //////////////////////////////

  // First slide-up word keeps the destination bytes below the amount
  assign lo_byte = (first_i && op_i == sld_pkg::SLD_UP) ? off : '0;

  always_comb begin
    for (int b = 0; b < wb; b++) begin
      wbe_o[b] = (b >= int'(lo_byte)) && (b < int'(lo_byte) + int'(delta_i));
    end
  end

  // Overflow register, also filled by the prefetch read
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ovf_q <= '0;
    end else if (clear_i) begin
      ovf_q <= '0;
    end else if (load_i) begin
      ovf_q <= spill;
    end
  end

endmodule

// File: sld_stage_reg.sv
// Stage register holding one payload of any type behind a valid/ready handshake
module sld_stage_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,

  // Upstream side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,

  // Downstream side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;
  logic push;

  // Room when empty, or when the held entry leaves in this cycle
  assign ready_o = !full_q || ready_i;
  assign push    = valid_i && ready_o;

  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Payload only moves on a push
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q <= data_i;
    end
  end

endmodule

// File: sld_unit.sv
// Vector slide unit moving VRF words up or down by a byte amount with write acknowledge
module sld_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Request
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  sld_pkg::sld_op_e     req_op_i,
  input  sld_pkg::vsew_e       req_vsew_i,
  input  sld_pkg::vlen_t       req_vl_i,
  input  sld_pkg::vlen_t       req_rs1_i,
  input  sld_pkg::vreg_idx_t   req_vs2_i,
  input  sld_pkg::vreg_idx_t   req_vd_i,
  input  sld_pkg::sld_id_t     req_id_i,

  // Response
  output logic                 rsp_valid_o,
  output sld_pkg::sld_id_t     rsp_id_o,

  // VRF read port
  output logic                 vrf_re_o,
  output sld_pkg::vreg_addr_t  vrf_raddr_o,
  input  sld_pkg::vreg_data_t  vrf_rdata_i,
  input  logic                 vrf_rvalid_i,

  // VRF write port
  output logic                 vrf_we_o,
  output sld_pkg::vreg_addr_t  vrf_waddr_o,
  output sld_pkg::vreg_data_t  vrf_wdata_o,
  output sld_pkg::vreg_be_t    vrf_wbe_o,
  input  logic                 vrf_wvalid_i
);

  sld_pkg::sld_req_t   req_d, req_q;
  sld_pkg::vrf_wreq_t  wreq_d, wreq_q;
  logic                req_valid, req_done;
  logic                prefetch, run, start, rd_accept;
  logic                wreg_ready;
  logic                first, last_done, first_straddle;
  sld_pkg::vlen_t      delta, count;
  sld_pkg::vreg_addr_t waddr;
  sld_pkg::vreg_data_t wdata;
  sld_pkg::vreg_be_t   wbe;

  //////////////////////////////
  // Request conversion
  //////////////////////////////

  // Element counts become byte counts
  always_comb begin
    req_d.op     = req_op_i;
    req_d.vsew   = req_vsew_i;
    req_d.vl     = req_vl_i << req_vsew_i;
    req_d.amount = req_rs1_i << req_vsew_i;
    req_d.vs2    = req_vs2_i;
    req_d.vd     = req_vd_i;
    req_d.id     = req_id_i;
  end

  sld_stage_reg #(.T(sld_pkg::sld_req_t)) i_req_reg (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .data_i (req_d),
    .valid_o(req_valid),
    .ready_i(req_done),
    .data_o (req_q)
  );

  sld_ctrl_fsm i_ctrl (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid),
    .op_i            (req_q.op),
    .req_id_i        (req_q.id),
    .first_straddle_i(first_straddle),
    .last_done_i     (last_done),
    .vrf_wvalid_i    (vrf_wvalid_i),
    .prefetch_o      (prefetch),
    .run_o           (run),
    .req_done_o      (req_done),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_id_o        (rsp_id_o)
  );

  // Counter and overflow reinitialize whenever no data is moving
  assign start     = !(prefetch || run);
  assign vrf_re_o  = (prefetch || run) && wreg_ready;
  assign rd_accept = vrf_re_o && vrf_rvalid_i;

  sld_byte_counter i_counter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .start_i         (start),
    .advance_i       (rd_accept),
    .prefetch_i      (prefetch),
    .vl_i            (req_q.vl),
    .amount_i        (req_q.amount),
    .op_i            (req_q.op),
    .vs2_i           (req_q.vs2),
    .vd_i            (req_q.vd),
    .first_o         (first),
    .last_o          (),
    .last_done_o     (last_done),
    .first_straddle_o(first_straddle),
    .delta_o         (delta),
    .count_o         (count),
    .raddr_o         (vrf_raddr_o),
    .waddr_o         (waddr)
  );

  sld_shifter i_shifter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .op_i    (req_q.op),
    .amount_i(req_q.amount),
    .count_i (count),
    .delta_i (delta),
    .first_i (first),
    .load_i  (rd_accept),
    .clear_i (start),
    .rdata_i (vrf_rdata_i),
    .wdata_o (wdata),
    .wbe_o   (wbe)
  );

  //////////////////////////////
  // Write register
  //////////////////////////////

  assign wreq_d = '{waddr: waddr, wdata: wdata, wbe: wbe};

  // Held until the VRF acknowledges with wvalid
  sld_stage_reg #(.T(sld_pkg::vrf_wreq_t)) i_wreq_reg (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(run && rd_accept),
    .ready_o(wreg_ready),
    .data_i (wreq_d),
    .valid_o(vrf_we_o),
    .ready_i(vrf_wvalid_i),
    .data_o (wreq_q)
  );

  assign vrf_waddr_o = wreq_q.waddr;
  assign vrf_wdata_o = wreq_q.wdata;
  assign vrf_wbe_o   = wreq_q.wbe;

endmodule

// File: sld_vrf_model.sv
// VRF model for the testbench with byte-enable writes and random read and write stalls
`include "sld_config.svh"

module sld_vrf_model (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Read port
  input  logic                 re_i,
  input  sld_pkg::vreg_addr_t  raddr_i,
  output sld_pkg::vreg_data_t  rdata_o,
  output logic                 rvalid_o,

  // Write port
  input  logic                 we_i,
  input  sld_pkg::vreg_addr_t  waddr_i,
  input  sld_pkg::vreg_data_t  wdata_i,
  input  sld_pkg::vreg_be_t    wbe_i,
  output logic                 wvalid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned nr_words = `SLD_NR_VREGS * `SLD_WORDS_PER_VREG;

  sld_pkg::vreg_data_t mem [nr_words];
  logic                rd_go_q;
  logic                wr_go_q;

  // Every byte depends on the full word address
  function automatic sld_pkg::vreg_data_t fill_word(input int unsigned addr);
    sld_pkg::vreg_data_t w;
    for (int b = 0; b < `SLD_WORD_BYTES; b++) begin
      w[8*b +: 8] = 8'(addr * 29 + b * 83 + 17);
    end
    return w;
  endfunction

  initial begin
    for (int a = 0; a < nr_words; a++) begin
      mem[a] = fill_word(a);
    end
  end

  // Roughly one cycle in four stalls on each port
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_go_q <= 1'b0;
      wr_go_q <= 1'b0;
    end else begin
      rd_go_q <= ($urandom_range(3, 0) != 0);
      wr_go_q <= ($urandom_range(3, 0) != 0);
    end
  end

  assign rvalid_o = re_i && rd_go_q;
  assign rdata_o  = mem[raddr_i];
  assign wvalid_o = we_i && wr_go_q;

  always @(posedge clk_i) begin
    if (we_i && wvalid_o) begin
      for (int b = 0; b < `SLD_WORD_BYTES; b++) begin
        if (wbe_i[b]) begin
          mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: tb_sld_unit.sv
// Testbench for the vector slide unit with a shadow VRF and random VRF stalls
`include "sld_config.svh"

module tb_sld_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned word_bytes = `SLD_WORD_BYTES;
  localparam int unsigned vreg_words = `SLD_WORDS_PER_VREG;
  localparam int unsigned vreg_bytes = word_bytes * vreg_words;
  localparam int unsigned nr_vregs   = `SLD_NR_VREGS;
  localparam int unsigned nr_words   = nr_vregs * vreg_words;

  // Sweeps at 8, 16 and 32 bits cover every amount at full length plus every shorter length
  localparam int unsigned n_sweep        = (2 * vreg_bytes - 1) + (vreg_bytes - 1)
                                         + (vreg_bytes / 2 - 1);
  localparam int unsigned n_random       = 40;
  localparam int unsigned n_requests     = n_sweep + n_random;
  localparam int unsigned timeout_cycles = 200 * n_requests + 10;

  logic                clk_i;
  logic                rst_n_i;
  logic                req_valid_i;
  logic                req_ready_o;
  sld_pkg::sld_op_e    req_op_i;
  sld_pkg::vsew_e      req_vsew_i;
  sld_pkg::vlen_t      req_vl_i;
  sld_pkg::vlen_t      req_rs1_i;
  sld_pkg::vreg_idx_t  req_vs2_i;
  sld_pkg::vreg_idx_t  req_vd_i;
  sld_pkg::sld_id_t    req_id_i;
  logic                rsp_valid_o;
  sld_pkg::sld_id_t    rsp_id_o;
  logic                vrf_re_o;
  sld_pkg::vreg_addr_t vrf_raddr_o;
  sld_pkg::vreg_data_t vrf_rdata_i;
  logic                vrf_rvalid_i;
  logic                vrf_we_o;
  sld_pkg::vreg_addr_t vrf_waddr_o;
  sld_pkg::vreg_data_t vrf_wdata_o;
  sld_pkg::vreg_be_t   vrf_wbe_o;
  logic                vrf_wvalid_i;

  sld_pkg::vreg_data_t shadow_mem [nr_words];
  sld_pkg::sld_id_t    next_id;
  int                  issued;

  always #5 clk_i = ~clk_i;

  sld_unit dut_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_vsew_i  (req_vsew_i),
    .req_vl_i    (req_vl_i),
    .req_rs1_i   (req_rs1_i),
    .req_vs2_i   (req_vs2_i),
    .req_vd_i    (req_vd_i),
    .req_id_i    (req_id_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_rdata_i (vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wvalid_i(vrf_wvalid_i)
  );

  sld_vrf_model vrf_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .re_i    (vrf_re_o),
    .raddr_i (vrf_raddr_o),
    .rdata_o (vrf_rdata_i),
    .rvalid_o(vrf_rvalid_i),
    .we_i    (vrf_we_o),
    .waddr_i (vrf_waddr_o),
    .wdata_i (vrf_wdata_o),
    .wbe_i   (vrf_wbe_o),
    .wvalid_o(vrf_wvalid_i)
  );

  bind sld_unit sld_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .vrf_wvalid_i(vrf_wvalid_i)
  );

  task automatic abort_run(input string why);
    $display("Testbench failed");
    $fatal(1, "%s", why);
  endtask

  // Slide rule on the shadow copy, byte by byte
  task automatic apply_slide(input sld_pkg::sld_op_e op, input sld_pkg::vsew_e vsew,
                             input int vl, input int amt, input int vs2, input int vd);
    logic [7:0] src [vreg_bytes];
    int         vl_b;
    int         amt_b;
    int         dst_w;
    vl_b  = vl << int'(vsew);
    amt_b = amt << int'(vsew);
    for (int j = 0; j < vreg_bytes; j++) begin
      src[j] = shadow_mem[vs2 * vreg_words + j / word_bytes][8 * (j % word_bytes) +: 8];
    end
    for (int j = 0; j < vl_b; j++) begin
      dst_w = vd * vreg_words + j / word_bytes;
      if (op == sld_pkg::SLD_DOWN) begin
        // Sources past the register end read as zero
        shadow_mem[dst_w][8 * (j % word_bytes) +: 8] =
          (j + amt_b < vreg_bytes) ? src[j + amt_b] : 8'h00;
      end else if (j >= amt_b) begin
        shadow_mem[dst_w][8 * (j % word_bytes) +: 8] = src[j - amt_b];
      end
    end
  endtask

  task automatic check_vreg(input int vd);
    sld_pkg::vreg_data_t got;
    sld_pkg::vreg_data_t exp;
    int                  a;
    for (int w = 0; w < vreg_words; w++) begin
      a   = vd * vreg_words + w;
      got = vrf_i.mem[a];
      exp = shadow_mem[a];
      if (got !== exp) begin
        $display("Error at %0t ns: v%0d word %0d is %08h, expected %08h",
                 $time, vd, w, got, exp);
        abort_run("destination register mismatch");
      end
    end
  endtask

  // Starts on a rising edge and returns on the edge that sees the response
  task automatic run_slide(input sld_pkg::sld_op_e op, input sld_pkg::vsew_e vsew,
                           input int vl, input int amt, input int vs2, input int vd);
    sld_pkg::sld_id_t id;
    id          = next_id;
    next_id     = next_id + 1'b1;
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_vsew_i  <= vsew;
    req_vl_i    <= sld_pkg::vlen_t'(vl);
    req_rs1_i   <= sld_pkg::vlen_t'(amt);
    req_vs2_i   <= sld_pkg::vreg_idx_t'(vs2);
    req_vd_i    <= sld_pkg::vreg_idx_t'(vd);
    req_id_i    <= id;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(posedge clk_i);
    while (!rsp_valid_o) @(posedge clk_i);
    if (rsp_id_o !== id) begin
      $display("Error at %0t ns: response id %0d, expected %0d", $time, rsp_id_o, id);
      abort_run("wrong response id");
    end
    apply_slide(op, vsew, vl, amt, vs2, vd);
    check_vreg(vd);
    issued++;
  endtask

  task automatic sweep_slides(input sld_pkg::sld_op_e op, input sld_pkg::vsew_e vsew);
    int elems;
    elems = vreg_bytes >> int'(vsew);
    for (int a = 0; a < elems; a++) begin
      run_slide(op, vsew, elems, a, issued % nr_vregs, (issued + 11) % nr_vregs);
    end
    for (int v = 1; v < elems; v++) begin
      run_slide(op, vsew, v, (2 * v) / 3, issued % nr_vregs, (issued + 11) % nr_vregs);
    end
  endtask

  task automatic random_slides(input int n);
    int unsigned      pick;
    int               elems;
    int               vl;
    int               amt;
    int               vs2;
    int               vd;
    sld_pkg::vsew_e   vsew;
    sld_pkg::sld_op_e op;
    for (int k = 0; k < n; k++) begin
      pick  = $urandom_range(2, 0);
      vsew  = sld_pkg::vsew_e'(pick[1:0]);
      pick  = $urandom_range(1, 0);
      op    = sld_pkg::sld_op_e'(pick[0]);
      elems = vreg_bytes >> int'(vsew);
      vl    = 1 + $urandom_range(elems - 1, 0);
      amt   = $urandom_range(vl - 1, 0);
      vs2   = $urandom_range(nr_vregs - 1, 0);
      // Destination never overlaps the source
      vd    = (vs2 + 1 + $urandom_range(nr_vregs - 2, 0)) % nr_vregs;
      run_slide(op, vsew, vl, amt, vs2, vd);
    end
  endtask

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Testbench failed");
    $fatal(1, "timeout, no response");
  end

  initial begin
    void'($urandom(32'h7f7b_b79a));
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = sld_pkg::SLD_UP;
    req_vsew_i  = sld_pkg::EW_8;
    req_vl_i    = '0;
    req_rs1_i   = '0;
    req_vs2_i   = '0;
    req_vd_i    = '0;
    req_id_i    = '0;
    next_id     = '0;
    issued      = 0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    // Shadow starts from the preloaded VRF contents
    for (int a = 0; a < nr_words; a++) begin
      shadow_mem[a] = vrf_i.mem[a];
    end
    sweep_slides(sld_pkg::SLD_UP, sld_pkg::EW_8);
    sweep_slides(sld_pkg::SLD_DOWN, sld_pkg::EW_16);
    sweep_slides(sld_pkg::SLD_DOWN, sld_pkg::EW_32);
    random_slides(n_random);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
sld_pkg.sv
sld_stage_reg.sv
sld_ctrl_fsm.sv
sld_byte_counter.sv
sld_shifter.sv
sld_unit.sv
sld_vrf_model.sv
sld_assertions.sv
tb_sld_unit.sv
